// File: src/snes_bus_pkg.sv
package snes_bus_pkg;

  // SNES cartridge bus
  localparam int SNES_ADDR_W = 24;
  localparam int SNES_DATA_W = 8;

  ////////////////////////////////////////////////////////////
  // Sampled strobes

  localparam int STROBE_COUNT = 3;
  localparam int STB_CPU_CLK  = 0;
  localparam int STB_READ     = 1;
  localparam int STB_WRITE    = 2;

  // Samples kept per strobe for edge filtering
  localparam int STROBE_HIST = 8;

  ////////////////////////////////////////////////////////////
  // Fixed cartridge mapping

  localparam logic [7:0] SAVERAM_BANK_FIRST = 8'h70;
  localparam logic [7:0] SAVERAM_BANK_LAST  = 8'h7D;

  // Save RAM lives near the top of the PSRAM
  localparam logic [23:0] SAVERAM_BASE = 24'hE00000;

endpackage

// File: src/psram_pkg.sv
package psram_pkg;

  // PSRAM, 16 bit wide, byte addressed on the request side
  localparam int MEM_ADDR_W      = 24;
  localparam int MEM_WORD_ADDR_W = 23;
  localparam int MEM_DATA_W      = 16;
  localparam int MEM_BYTE_W      = MEM_DATA_W / 2;

  ////////////////////////////////////////////////////////////
  // Wait counts, one more cycle than the value is spent

  localparam int DELAY_W = 4;

  localparam logic [DELAY_W-1:0] RD_WAIT_SNES  = 4'd4;
  localparam logic [DELAY_W-1:0] WR_WAIT1_SNES = 4'd2;
  localparam logic [DELAY_W-1:0] WR_WAIT2_SNES = 4'd3;
  localparam logic [DELAY_W-1:0] RD_WAIT_MCU   = 4'd6;
  localparam logic [DELAY_W-1:0] WR_WAIT_MCU   = 4'd6;
  localparam logic [DELAY_W-1:0] RD_WAIT_CX4   = 4'd6;
  localparam logic [DELAY_W-1:0] RECOVER_WAIT  = 4'd2;

  ////////////////////////////////////////////////////////////
  // Arbiter states

  typedef enum logic [4:0] {
    ST_IDLE,
    ST_SNES_RD_ADDR,
    ST_SNES_RD_WAIT,
    ST_SNES_RD_END,
    ST_SNES_WR_ADDR,
    ST_SNES_WR_WAIT1,
    ST_SNES_WR_DATA,
    ST_SNES_WR_WAIT2,
    ST_SNES_WR_END,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_WAIT,
    ST_MCU_RD_WAIT2,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_WAIT,
    ST_MCU_WR_WAIT2,
    ST_MCU_WR_END,
    ST_CX4_RD_WAIT
  } arb_state_t;

  ////////////////////////////////////////////////////////////
  // Requester payloads

  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_BYTE_W-1:0] wdata;
    logic                  write;
  } mcu_req_t;

  typedef struct packed {
    logic [MEM_ADDR_W-1:0] addr;
  } cx4_req_t;

endpackage

// File: src/snes_bus_sync.sv
`timescale 1ns/10ps

module snes_bus_sync (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr_in,
  input  logic                                 snes_cpu_clk,
  input  logic                                 snes_read_n,
  input  logic                                 snes_write_n,
  output logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr,
  output logic                                 strobe_smp [snes_bus_pkg::STROBE_COUNT]
);

  import snes_bus_pkg::*;

  logic [SNES_ADDR_W-1:0] addr_q [3];
  logic [1:0]             cpu_q;
  logic                   read_q;
  logic                   write_q;

  // Address pipeline, bits must agree in two samples
  always_ff @(posedge CLK2) begin
    addr_q[0] <= snes_addr_in;
    addr_q[1] <= addr_q[0];
    addr_q[2] <= addr_q[1];
  end

  assign snes_addr = addr_q[2] & addr_q[1];

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_q   <= 2'b11;
      read_q  <= 1'b1;
      write_q <= 1'b1;
    end else begin
      cpu_q   <= {cpu_q[0], snes_cpu_clk};
      read_q  <= snes_read_n;
      write_q <= snes_write_n;
    end
  end

  // Short high glitches on the CPU clock are dropped here
  assign strobe_smp[STB_CPU_CLK] = &cpu_q;
  assign strobe_smp[STB_READ]    = read_q;
  assign strobe_smp[STB_WRITE]   = write_q;

endmodule

// File: src/strobe_edge.sv
`timescale 1ns/10ps

module strobe_edge (
  input  logic CLK2,
  input  logic rst_n,
  input  logic smp,
  output logic rise,
  output logic fall
);

  import snes_bus_pkg::*;

  logic [STROBE_HIST-1:0] hist;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      hist <= '1;
    end else begin
      hist <= {hist[STROBE_HIST-2:0], smp};
    end
  end

  // Six steady samples, then one at the new level
  assign rise = (hist[STROBE_HIST-1:1] == {{(STROBE_HIST-2){1'b0}}, 1'b1});
  assign fall = (hist[STROBE_HIST-1:1] == {{(STROBE_HIST-2){1'b1}}, 1'b0});

endmodule

// File: src/address_map.sv
`timescale 1ns/10ps

module address_map (
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0] snes_addr,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]     rom_mask,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]     saveram_mask,
  output logic                                 is_rom,
  output logic                                 is_saveram,
  output logic [psram_pkg::MEM_ADDR_W-1:0]     mapped_addr
);

  import snes_bus_pkg::*;
  import psram_pkg::*;

  logic [7:0]            bank;
  logic [MEM_ADDR_W-1:0] rom_offset;
  logic [MEM_ADDR_W-1:0] sram_offset;

  assign bank = snes_addr[SNES_ADDR_W-1:16];

  ////////////////////////////////////////////////////////////
  // Region decode

  assign is_rom     = snes_addr[15];
  assign is_saveram = !snes_addr[15] &&
                      (bank >= SAVERAM_BANK_FIRST) && (bank <= SAVERAM_BANK_LAST);

  ////////////////////////////////////////////////////////////
  // PSRAM byte address

  // 32 KiB of ROM per bank, upper half of each bank
  assign rom_offset  = MEM_ADDR_W'({bank[6:0], snes_addr[14:0]}) & rom_mask;
  // Save RAM in the lower half of banks 70 to 7D
  assign sram_offset = MEM_ADDR_W'({bank[3:0], snes_addr[14:0]}) & saveram_mask;

  assign mapped_addr = is_saveram ? (SAVERAM_BASE + sram_offset) : rom_offset;

endmodule

// File: src/request_slot.sv
`timescale 1ns/10ps

module request_slot #(
  parameter type payload_t = logic
) (
  input  logic     CLK2,
  input  logic     rst_n,
  input  logic     rq,
  input  payload_t rq_payload,
  input  logic     done,
  output logic     pending,
  output payload_t payload,
  output logic     rdy
);

  logic accept;

  // Pulses seen while busy are dropped
  assign accept = rq && !pending;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  always_ff @(posedge CLK2) begin
    if (accept) begin
      payload <= rq_payload;
    end
  end

  assign rdy = !pending;

endmodule

// File: src/psram_arbiter.sv
`timescale 1ns/10ps

module psram_arbiter (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  input  logic                                 cyc_start,
  input  logic                                 cyc_end,
  input  logic                                 rd_fall,
  input  logic                                 wr_fall,
  input  logic                                 is_rom,
  input  logic                                 is_saveram,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]     mapped_addr,
  input  logic                                 cx4_active,
  input  logic                                 mcu_pending,
  input  psram_pkg::mcu_req_t                  mcu_payload,
  input  logic                                 cx4_pending,
  input  psram_pkg::cx4_req_t                  cx4_payload,
  input  logic [snes_bus_pkg::SNES_DATA_W-1:0] snes_data_in,
  input  logic                                 snes_read_n,
  input  logic                                 snes_write_n,
  input  logic [psram_pkg::MEM_DATA_W-1:0]     rom_data_in,
  output logic                                 mcu_done,
  output logic                                 cx4_done,
  output logic [psram_pkg::MEM_BYTE_W-1:0]     mcu_rdata,
  output logic [psram_pkg::MEM_BYTE_W-1:0]     cx4_rdata,
  output logic [psram_pkg::MEM_WORD_ADDR_W-1:0] rom_addr,
  output logic [psram_pkg::MEM_DATA_W-1:0]     rom_data_out,
  output logic                                 rom_data_oe [2],
  output logic                                 rom_we_n,
  output logic                                 rom_bhe_n,
  output logic                                 rom_ble_n,
  output logic [snes_bus_pkg::SNES_DATA_W-1:0] snes_data_out,
  output logic                                 snes_data_oe,
  output logic                                 snes_databus_oe_n
);

  import snes_bus_pkg::*;
  import psram_pkg::*;

  arb_state_t            state;
  arb_state_t            state_d;
  logic [DELAY_W-1:0]    delay;
  logic [DELAY_W-1:0]    delay_d;
  logic                  last;
  logic                  is_cart;
  logic                  snes_go;
  logic                  need_snes;
  logic                  snes_wr_ok;
  logic                  we_d;
  logic [MEM_ADDR_W-1:0] rom_addr_r;
  logic [MEM_BYTE_W-1:0] rom_dout_r;
  logic [MEM_BYTE_W-1:0] rom_byte;

  assign is_cart = is_rom | is_saveram;
  assign snes_go = is_cart & ~cx4_active;
  assign last    = (delay == '0);

  ////////////////////////////////////////////////////////////
  // Next state

  always_comb begin
    state_d = state;
    // Counter runs down on its own and stops at zero
    delay_d = last ? delay : delay - 1'b1;
    if (cyc_start && snes_go) begin
      state_d = ST_SNES_RD_ADDR;
    end else if (wr_fall && snes_go) begin
      state_d = ST_SNES_WR_ADDR;
    end else if (rd_fall && need_snes && snes_go) begin
      // Late fetch when the cycle start found no cart address
      state_d = ST_SNES_RD_ADDR;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cx4_pending) begin
            state_d = ST_CX4_RD_WAIT;
            delay_d = RD_WAIT_CX4;
          end else if (mcu_pending && !cx4_active) begin
            state_d = mcu_payload.write ? ST_MCU_WR_ADDR : ST_MCU_RD_ADDR;
          end
        end
        ST_SNES_RD_ADDR: begin
          state_d = ST_SNES_RD_WAIT;
          delay_d = RD_WAIT_SNES;
        end
        ST_SNES_RD_WAIT: if (last) state_d = ST_SNES_RD_END;
        ST_SNES_WR_ADDR: begin
          state_d = ST_SNES_WR_WAIT1;
          delay_d = WR_WAIT1_SNES;
        end
        ST_SNES_WR_WAIT1: if (last) state_d = ST_SNES_WR_DATA;
        ST_SNES_WR_DATA: begin
          state_d = ST_SNES_WR_WAIT2;
          delay_d = WR_WAIT2_SNES;
        end
        ST_SNES_WR_WAIT2: if (last) state_d = ST_SNES_WR_END;
        ST_MCU_RD_ADDR: begin
          state_d = ST_MCU_RD_WAIT;
          delay_d = RD_WAIT_MCU;
        end
        ST_MCU_RD_WAIT: begin
          if (last) begin
            state_d = ST_MCU_RD_WAIT2;
            delay_d = RECOVER_WAIT;
          end
        end
        ST_MCU_RD_WAIT2: if (last) state_d = ST_MCU_RD_END;
        ST_MCU_WR_ADDR: begin
          state_d = ST_MCU_WR_WAIT;
          delay_d = WR_WAIT_MCU;
        end
        ST_MCU_WR_WAIT: begin
          if (last) begin
            state_d = ST_MCU_WR_WAIT2;
            delay_d = RECOVER_WAIT;
          end
        end
        ST_MCU_WR_WAIT2: if (last) state_d = ST_MCU_WR_END;
        ST_CX4_RD_WAIT: if (last) state_d = ST_IDLE;
        default: state_d = ST_IDLE;
      endcase
    end
  end

  // Only save RAM takes SNES writes
  assign we_d = (state_d == ST_MCU_WR_WAIT) ||
                (snes_wr_ok && (state_d inside {ST_SNES_WR_WAIT1, ST_SNES_WR_DATA,
                                                ST_SNES_WR_WAIT2}));

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      delay      <= '0;
      rom_we_n   <= 1'b1;
      snes_wr_ok <= 1'b0;
      need_snes  <= 1'b0;
    end else begin
      state    <= state_d;
      delay    <= delay_d;
      rom_we_n <= ~we_d;
      if (state_d == ST_SNES_WR_ADDR) begin
        snes_wr_ok <= is_saveram;
      end
      if (cyc_end) begin
        need_snes <= 1'b1;
      end else if (state_d == ST_SNES_RD_ADDR || state_d == ST_SNES_WR_ADDR) begin
        need_snes <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and data registers

  assign rom_byte = rom_addr_r[0] ? rom_data_in[MEM_BYTE_W-1:0]
                                  : rom_data_in[MEM_DATA_W-1:MEM_BYTE_W];

  always_ff @(posedge CLK2) begin
    case (state_d)
      ST_SNES_RD_ADDR, ST_SNES_WR_ADDR: rom_addr_r <= mapped_addr;
      ST_MCU_RD_ADDR: rom_addr_r <= mcu_payload.addr;
      ST_MCU_WR_ADDR: begin
        rom_addr_r <= mcu_payload.addr;
        rom_dout_r <= mcu_payload.wdata;
      end
      ST_CX4_RD_WAIT: if (state != ST_CX4_RD_WAIT) rom_addr_r <= cx4_payload.addr;
      default: ;
    endcase
    if (state == ST_SNES_WR_DATA) begin
      rom_dout_r <= snes_data_in;
    end
    if (state == ST_SNES_RD_END) begin
      snes_data_out <= rom_byte;
    end
    if (state == ST_MCU_RD_WAIT && last) begin
      mcu_rdata <= rom_byte;
    end
    if (cx4_done) begin
      cx4_rdata <= rom_byte;
    end
  end

  assign mcu_done = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);
  assign cx4_done = (state == ST_CX4_RD_WAIT) && last;

  ////////////////////////////////////////////////////////////
  // PSRAM and SNES pins

  assign rom_addr = rom_addr_r[MEM_ADDR_W-1:1];

  // Odd byte on the low lane
  assign rom_data_out   = rom_addr_r[0] ? {{MEM_BYTE_W{1'b0}}, rom_dout_r}
                                        : {rom_dout_r, {MEM_BYTE_W{1'b0}}};
  assign rom_data_oe[0] = ~rom_we_n & rom_addr_r[0];
  assign rom_data_oe[1] = ~rom_we_n & ~rom_addr_r[0];
  assign rom_bhe_n      = ~rom_we_n & rom_addr_r[0];
  assign rom_ble_n      = ~rom_we_n & ~rom_addr_r[0];

  assign snes_data_oe      = ~snes_read_n & is_cart;
  assign snes_databus_oe_n = ~is_cart | (snes_read_n & snes_write_n);

endmodule

// File: src/cart_bus_top.sv
`timescale 1ns/10ps

module cart_bus_top (
  input  logic                                  CLK2,
  input  logic                                  rst_n,
  input  logic [snes_bus_pkg::SNES_ADDR_W-1:0]  snes_addr_in,
  input  logic                                  snes_cpu_clk,
  input  logic                                  snes_read_n,
  input  logic                                  snes_write_n,
  input  logic [snes_bus_pkg::SNES_DATA_W-1:0]  snes_data_in,
  output logic [snes_bus_pkg::SNES_DATA_W-1:0]  snes_data_out,
  output logic                                  snes_data_oe,
  output logic                                  snes_databus_oe_n,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]      rom_mask,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]      saveram_mask,
  input  logic                                  mcu_rrq,
  input  logic                                  mcu_wrq,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]      mcu_addr,
  input  logic [psram_pkg::MEM_BYTE_W-1:0]      mcu_wdata,
  output logic                                  mcu_rdy,
  output logic [psram_pkg::MEM_BYTE_W-1:0]      mcu_rdata,
  input  logic                                  cx4_rrq,
  input  logic [psram_pkg::MEM_ADDR_W-1:0]      cx4_addr,
  input  logic                                  cx4_active,
  output logic                                  cx4_rdy,
  output logic [psram_pkg::MEM_BYTE_W-1:0]      cx4_rdata,
  output logic [psram_pkg::MEM_WORD_ADDR_W-1:0] rom_addr,
  input  logic [psram_pkg::MEM_DATA_W-1:0]      rom_data_in,
  output logic [psram_pkg::MEM_DATA_W-1:0]      rom_data_out,
  output logic                                  rom_data_oe [2],
  output logic                                  rom_we_n,
  output logic                                  rom_bhe_n,
  output logic                                  rom_ble_n
);

  import snes_bus_pkg::*;
  import psram_pkg::*;

  logic [SNES_ADDR_W-1:0] snes_addr;
  logic                   strobe_smp [STROBE_COUNT];
  logic                   rise_ev [STROBE_COUNT];
  logic                   fall_ev [STROBE_COUNT];
  logic                   is_rom;
  logic                   is_saveram;
  logic [MEM_ADDR_W-1:0]  mapped_addr;
  mcu_req_t               mcu_rq_payload;
  mcu_req_t               mcu_payload;
  logic                   mcu_pending;
  logic                   mcu_done;
  cx4_req_t               cx4_rq_payload;
  cx4_req_t               cx4_payload;
  logic                   cx4_pending;
  logic                   cx4_done;

  ////////////////////////////////////////////////////////////
  // SNES side

  snes_bus_sync u_sync (
    .CLK2, .rst_n, .snes_addr_in, .snes_cpu_clk, .snes_read_n, .snes_write_n,
    .snes_addr, .strobe_smp
  );

  for (genvar i = 0; i < STROBE_COUNT; i++) begin : g_edge
    strobe_edge u_edge (
      .CLK2, .rst_n, .smp(strobe_smp[i]), .rise(rise_ev[i]), .fall(fall_ev[i])
    );
  end

  address_map u_map (
    .snes_addr, .rom_mask, .saveram_mask, .is_rom, .is_saveram, .mapped_addr
  );

  ////////////////////////////////////////////////////////////
  // Requesters

  assign mcu_rq_payload = '{addr: mcu_addr, wdata: mcu_wdata, write: mcu_wrq};
  assign cx4_rq_payload = '{addr: cx4_addr};

  request_slot #(.payload_t(mcu_req_t)) u_mcu_slot (
    .CLK2, .rst_n, .rq(mcu_rrq | mcu_wrq), .rq_payload(mcu_rq_payload), .done(mcu_done),
    .pending(mcu_pending), .payload(mcu_payload), .rdy(mcu_rdy)
  );

  request_slot #(.payload_t(cx4_req_t)) u_cx4_slot (
    .CLK2, .rst_n, .rq(cx4_rrq), .rq_payload(cx4_rq_payload), .done(cx4_done),
    .pending(cx4_pending), .payload(cx4_payload), .rdy(cx4_rdy)
  );

  ////////////////////////////////////////////////////////////
  // PSRAM arbiter

  psram_arbiter u_arb (
    .CLK2, .rst_n,
    .cyc_start(rise_ev[STB_CPU_CLK]), .cyc_end(fall_ev[STB_CPU_CLK]),
    .rd_fall(fall_ev[STB_READ]), .wr_fall(fall_ev[STB_WRITE]),
    .is_rom, .is_saveram, .mapped_addr, .cx4_active,
    .mcu_pending, .mcu_payload, .cx4_pending, .cx4_payload,
    .snes_data_in, .snes_read_n, .snes_write_n, .rom_data_in,
    .mcu_done, .cx4_done, .mcu_rdata, .cx4_rdata,
    .rom_addr, .rom_data_out, .rom_data_oe, .rom_we_n, .rom_bhe_n, .rom_ble_n,
    .snes_data_out, .snes_data_oe, .snes_databus_oe_n
  );

endmodule

// File: tests/cart_bus_tasks.svh
`ifndef CART_BUS_TASKS_SVH
`define CART_BUS_TASKS_SVH

////////////////////////////////////////////////////////////
// Timing and compare helpers

// Drive point just after the rising edge
task automatic tick();
  @(posedge CLK2);
  #0.5;
endtask

task automatic hold_cycles(input int cycles);
  repeat (cycles) tick();
endtask

task automatic check_byte(input string name, input logic [SNES_DATA_W-1:0] got,
                          input logic [SNES_DATA_W-1:0] exp);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0.1f ns: %s = %02h, expected %02h",
                       $realtime, name, got, exp));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0.1f ns: %s = %b, expected %b",
                       $realtime, name, got, exp));
  end
endtask

////////////////////////////////////////////////////////////
// Expected values

function automatic logic [MEM_BYTE_W-1:0] model_byte(input logic [MEM_ADDR_W-1:0] a);
  logic [MEM_DATA_W-1:0] w;
  w = psram_mem[a[MEM_ADDR_W-1:1]];
  // Odd bytes on the low lane
  return a[0] ? w[MEM_BYTE_W-1:0] : w[MEM_DATA_W-1:MEM_BYTE_W];
endfunction

function automatic logic [MEM_BYTE_W-1:0] fill_byte(input logic [MEM_ADDR_W-1:0] a);
  logic [MEM_DATA_W-1:0] w;
  w = fill_word(a[MEM_ADDR_W-1:1]);
  return a[0] ? w[MEM_BYTE_W-1:0] : w[MEM_DATA_W-1:MEM_BYTE_W];
endfunction

function automatic logic [MEM_ADDR_W-1:0] rom_offset_of(input logic [SNES_ADDR_W-1:0] a);
  return MEM_ADDR_W'({a[22:16], a[14:0]}) & ROM_MASK;
endfunction

function automatic logic [MEM_ADDR_W-1:0] saveram_offset_of(input logic [SNES_ADDR_W-1:0] a);
  return SAVERAM_BASE + (MEM_ADDR_W'({a[19:16], a[14:0]}) & SAVERAM_MASK);
endfunction

////////////////////////////////////////////////////////////
// Bus drivers

task automatic wait_mcu_ready();
  int n;
  n = 0;
  @(negedge CLK2);
  while (!mcu_rdy && n < WAIT_LIMIT) begin
    @(negedge CLK2);
    n++;
  end
  if (!mcu_rdy) fail_run("mcu_rdy stayed low past the wait limit");
endtask

task automatic wait_both_ready(output int cx4_at, output int mcu_at);
  int n;
  n = 0;
  cx4_at = -1;
  mcu_at = -1;
  while ((cx4_at < 0 || mcu_at < 0) && n < WAIT_LIMIT) begin
    @(negedge CLK2);
    if (cx4_rdy && cx4_at < 0) cx4_at = n;
    if (mcu_rdy && mcu_at < 0) mcu_at = n;
    n++;
  end
  if (cx4_at < 0 || mcu_at < 0) fail_run("cx4_rdy or mcu_rdy stayed low past the wait limit");
endtask

task automatic mcu_access(input logic write, input logic [MEM_ADDR_W-1:0] addr,
                          input logic [MEM_BYTE_W-1:0] wdata,
                          output logic [MEM_BYTE_W-1:0] rdata);
  tick();
  mcu_addr  = addr;
  mcu_wdata = wdata;
  mcu_wrq   = write;
  mcu_rrq   = !write;
  tick();
  mcu_wrq = 1'b0;
  mcu_rrq = 1'b0;
  check_flag("mcu_rdy", mcu_rdy, 1'b0);
  wait_mcu_ready();
  rdata = mcu_rdata;
endtask

// CPU clock low phase and the rising edge that opens the cycle
task automatic snes_cycle_start(input logic [SNES_ADDR_W-1:0] addr);
  tick();
  snes_addr_in = addr;
  snes_cpu_clk = 1'b0;
  hold_cycles(CLK_LOW_CYCLES);
  snes_cpu_clk = 1'b1;
  hold_cycles(2);
endtask

task automatic snes_read(input logic [SNES_ADDR_W-1:0] addr,
                         output logic [SNES_DATA_W-1:0] data);
  snes_cycle_start(addr);
  snes_read_n = 1'b0;
  hold_cycles(SNES_HOLD);
  @(negedge CLK2);
  check_flag("snes_data_oe", snes_data_oe, 1'b1);
  data = snes_data_out;
  tick();
  snes_read_n = 1'b1;
  hold_cycles(QUIET_CYCLES);
endtask

task automatic snes_write(input logic [SNES_ADDR_W-1:0] addr,
                          input logic [SNES_DATA_W-1:0] data, input logic expect_we);
  logic we_seen;
  we_seen = 1'b0;
  snes_cycle_start(addr);
  snes_write_n = 1'b0;
  snes_data_in = data;
  repeat (SNES_HOLD) begin
    @(negedge CLK2);
    we_seen = we_seen | !rom_we_n;
    tick();
  end
  check_flag("rom_we_n pulse", we_seen, expect_we);
  snes_write_n = 1'b1;
  hold_cycles(QUIET_CYCLES);
endtask

////////////////////////////////////////////////////////////
// Directed tests

task automatic reset_levels();
  @(negedge CLK2);
  check_flag("mcu_rdy", mcu_rdy, 1'b1);
  check_flag("cx4_rdy", cx4_rdy, 1'b1);
  check_flag("rom_we_n", rom_we_n, 1'b1);
  check_flag("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
  check_flag("snes_data_oe", snes_data_oe, 1'b0);
  check_flag("rom_data_oe[0]", rom_data_oe[0], 1'b0);
  check_flag("rom_data_oe[1]", rom_data_oe[1], 1'b0);
endtask

task automatic mcu_round_trip();
  logic [MEM_ADDR_W-1:0] odd_a;
  logic [MEM_ADDR_W-1:0] even_a;
  logic [MEM_BYTE_W-1:0] d_odd;
  logic [MEM_BYTE_W-1:0] d_even;
  logic [MEM_BYTE_W-1:0] got;
  odd_a  = 24'h012345;
  even_a = 24'h012344;
  d_odd  = 8'($urandom());
  d_even = 8'($urandom());
  mcu_access(1'b1, odd_a, d_odd, got);
  check_byte("psram low lane", model_byte(odd_a), d_odd);
  check_byte("psram high lane", model_byte(even_a), fill_byte(even_a));
  mcu_access(1'b1, even_a, d_even, got);
  check_byte("psram high lane", model_byte(even_a), d_even);
  check_byte("psram low lane", model_byte(odd_a), d_odd);
  mcu_access(1'b0, odd_a, 8'h00, got);
  check_byte("mcu_rdata", got, d_odd);
  mcu_access(1'b0, even_a, 8'h00, got);
  check_byte("mcu_rdata", got, d_even);
endtask

task automatic snes_rom_read();
  logic [SNES_DATA_W-1:0] got;
  snes_read(24'hC39ABD, got);
  check_byte("snes_data_out", got, model_byte(rom_offset_of(24'hC39ABD)));
  snes_read(24'h8A8000, got);
  check_byte("snes_data_out", got, model_byte(rom_offset_of(24'h8A8000)));
endtask

task automatic snes_saveram_write();
  logic [MEM_ADDR_W-1:0]  waddr;
  logic [SNES_DATA_W-1:0] d;
  d     = 8'($urandom());
  waddr = saveram_offset_of(24'h721234);
  snes_write(24'h721234, d, 1'b1);
  check_byte("saveram byte", model_byte(waddr), d);
  check_byte("saveram other lane", model_byte(waddr ^ MEM_ADDR_W'(1)),
             fill_byte(waddr ^ MEM_ADDR_W'(1)));
  // ROM is read only from the SNES side
  snes_write(24'hC5F000, ~d, 1'b0);
  check_byte("rom byte", model_byte(rom_offset_of(24'hC5F000)),
             fill_byte(rom_offset_of(24'hC5F000)));
endtask

task automatic cx4_with_mcu();
  int cx4_at;
  int mcu_at;
  tick();
  cx4_addr = 24'h0A5F03;
  cx4_rrq  = 1'b1;
  mcu_addr = 24'h012345;
  mcu_rrq  = 1'b1;
  tick();
  cx4_rrq = 1'b0;
  mcu_rrq = 1'b0;
  check_flag("cx4_rdy", cx4_rdy, 1'b0);
  check_flag("mcu_rdy", mcu_rdy, 1'b0);
  wait_both_ready(cx4_at, mcu_at);
  if (cx4_at > mcu_at) fail_run("cx4_rdy rose after mcu_rdy");
  check_byte("cx4_rdata", cx4_rdata, model_byte(24'h0A5F03));
  check_byte("mcu_rdata", mcu_rdata, model_byte(24'h012345));
endtask

`endif

// File: tests/tb_cart_bus.sv
`timescale 1ns/10ps

module tb_cart_bus;

  import snes_bus_pkg::*;
  import psram_pkg::*;

  localparam logic [MEM_ADDR_W-1:0] ROM_MASK     = 24'h0FFFFF;
  localparam logic [MEM_ADDR_W-1:0] SAVERAM_MASK = 24'h001FFF;
  localparam int PSRAM_WORDS    = 2 ** MEM_WORD_ADDR_W;
  localparam int WAIT_LIMIT     = 100;
  localparam int CLK_LOW_CYCLES = 10;
  localparam int SNES_HOLD      = 18;
  localparam int QUIET_CYCLES   = 8;

  logic                       CLK2 = 1'b0;
  logic                       rst_n;
  logic [SNES_ADDR_W-1:0]     snes_addr_in;
  logic                       snes_cpu_clk;
  logic                       snes_read_n;
  logic                       snes_write_n;
  logic [SNES_DATA_W-1:0]     snes_data_in;
  logic [SNES_DATA_W-1:0]     snes_data_out;
  logic                       snes_data_oe;
  logic                       snes_databus_oe_n;
  logic [MEM_ADDR_W-1:0]      rom_mask;
  logic [MEM_ADDR_W-1:0]      saveram_mask;
  logic                       mcu_rrq;
  logic                       mcu_wrq;
  logic [MEM_ADDR_W-1:0]      mcu_addr;
  logic [MEM_BYTE_W-1:0]      mcu_wdata;
  logic                       mcu_rdy;
  logic [MEM_BYTE_W-1:0]      mcu_rdata;
  logic                       cx4_rrq;
  logic [MEM_ADDR_W-1:0]      cx4_addr;
  logic                       cx4_active;
  logic                       cx4_rdy;
  logic [MEM_BYTE_W-1:0]      cx4_rdata;
  logic [MEM_WORD_ADDR_W-1:0] rom_addr;
  logic [MEM_DATA_W-1:0]      rom_data_in;
  logic [MEM_DATA_W-1:0]      rom_data_out;
  logic                       rom_data_oe [2];
  logic                       rom_we_n;
  logic                       rom_bhe_n;
  logic                       rom_ble_n;

  logic [MEM_DATA_W-1:0] psram_mem [PSRAM_WORDS];

  always #2 CLK2 = ~CLK2;

  cart_bus_top UUT (.*);

  ////////////////////////////////////////////////////////////
  // PSRAM model

  // Every address bit shows up in the pattern
  function automatic logic [MEM_DATA_W-1:0] fill_word(input logic [MEM_WORD_ADDR_W-1:0] a);
    return a[15:0] ^ {a[22:16], a[22:14]} ^ 16'hC35A;
  endfunction

  assign rom_data_in = psram_mem[rom_addr];

  initial begin
    for (int i = 0; i < PSRAM_WORDS; i++) begin
      psram_mem[MEM_WORD_ADDR_W'(i)] = fill_word(MEM_WORD_ADDR_W'(i));
    end
    forever begin
      @(negedge CLK2);
      if (!rom_we_n) begin
        if (!rom_ble_n) psram_mem[rom_addr][MEM_BYTE_W-1:0] = rom_data_out[MEM_BYTE_W-1:0];
        if (!rom_bhe_n) begin
          psram_mem[rom_addr][MEM_DATA_W-1:MEM_BYTE_W] = rom_data_out[MEM_DATA_W-1:MEM_BYTE_W];
        end
      end
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  `include "cart_bus_tasks.svh"

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    void'($urandom(32'ha1cd_5ed6));
    rst_n        = 1'b0;
    snes_addr_in = '0;
    snes_cpu_clk = 1'b1;
    snes_read_n  = 1'b1;
    snes_write_n = 1'b1;
    snes_data_in = '0;
    rom_mask     = ROM_MASK;
    saveram_mask = SAVERAM_MASK;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    cx4_rrq      = 1'b0;
    cx4_addr     = '0;
    cx4_active   = 1'b0;
    repeat (8) @(posedge CLK2);
    #0.5;
    rst_n = 1'b1;
    reset_levels();
    mcu_round_trip();
    snes_rom_read();
    snes_saveram_write();
    cx4_with_mcu();
    $display("All checks passed");
    $finish;
  end

endmodule

// File: build.f
+incdir+tests
src/snes_bus_pkg.sv
src/psram_pkg.sv
src/snes_bus_sync.sv
src/strobe_edge.sv
src/address_map.sv
src/request_slot.sv
src/psram_arbiter.sv
src/cart_bus_top.sv
tests/tb_cart_bus.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -j 0 \
  --top-module tb_cart_bus -f build.f -o sim_cart_bus

./obj_dir/sim_cart_bus > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi
